// File: dv/btb_assert.sv
`timescale 1ns/100ps
`default_nettype none

`include "btb_settings.svh"

// protocol checks on the btb top level, attached by bind
module btb_assert (
  input  logic          clk,
  input  logic          rst,
  input  logic          pred_valid,
  input  logic          takb,
  input  btb_pkg::pc_t  next_pc,
  input  logic          branch_miss,
  input  btb_pkg::pc_t  miss_pc,
  input  logic          we,                        // row write strobe inside the top
  input  logic          commit_takb [`BTB_LANES]
);

  logic any_takb;  // some commit lane taken this cycle

  always_comb begin
    any_takb = 1'b0;
    for (int k = 0; k < `BTB_LANES; k++) begin
      any_takb = any_takb | commit_takb[k];
    end
  end

  // ====================
  // properties
  // ====================
  reset_clears : assert property (@(posedge clk) rst |=> (!pred_valid && !we))
    else $error("pred_valid or we still high after a reset edge");

  // strobe is the registered OR of the taken lanes
  we_follows_commit : assert property (@(posedge clk) !rst |=> (we == $past(any_takb)))
    else $error("row write strobe does not match the taken lanes of the last commit");

  miss_redirects : assert property (@(posedge clk)
      (!rst && branch_miss) |=> (pred_valid && takb && next_pc == $past(miss_pc)))
    else $error("branch miss did not redirect to miss_pc one cycle later");

endmodule

bind btb_top btb_assert i_btb_assert (
  .clk         (clk),
  .rst         (rst),
  .pred_valid  (pred_valid),
  .takb        (takb),
  .next_pc     (next_pc),
  .branch_miss (branch_miss),
  .miss_pc     (miss_pc),
  .we          (ram_if.we),
  .commit_takb (commit_takb)
);

`default_nettype wire

// File: dv/btb_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "btb_settings.svh"

module btb_tb;

  // ====================
  // run length
  // ====================
  localparam int CLK_PERIOD      = 100;   // ns
  localparam int RESET_CYCLES    = 4;
  localparam int DIRECTED_CYCLES = 20;    // directed steps plus the final flush
  localparam int NUM_RANDOM      = 2000;
  localparam int TEST_CYCLES     = DIRECTED_CYCLES + NUM_RANDOM;

  logic          clk;
  logic          rst;
  logic          fetch_valid;
  btb_pkg::pc_t  fetch_pc;
  logic          branch_miss;
  btb_pkg::pc_t  miss_pc;
  btb_pkg::pc_t  commit_pc   [`BTB_LANES];
  btb_pkg::pc_t  commit_tgt  [`BTB_LANES];
  logic          commit_takb [`BTB_LANES];
  logic          pred_valid;
  btb_pkg::pc_t  next_pc;
  logic          takb;

  integer seed = 32'h2f41_1c14;           // fixed seed for $random

  btb_pkg::pc_t       pool [16];          // block bases on their own rows
  btb_pkg::btb_row_t  model_row [int];    // reference table where an absent row reads as zero
  logic               pend_we;            // commit sampled last edge that lands on this edge
  int                 pend_idx;
  btb_pkg::btb_row_t  pend_row;
  int                 hit_count;          // random lookups that predicted a taken lane

  btb_top i_btb_top (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .branch_miss (branch_miss),
    .miss_pc     (miss_pc),
    .commit_pc   (commit_pc),
    .commit_tgt  (commit_tgt),
    .commit_takb (commit_takb),
    .pred_valid  (pred_valid),
    .next_pc     (next_pc),
    .takb        (takb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // hard stop in case the DUT or the sequence stalls
  initial begin
    #((RESET_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD);
    $display("Test failures found");
    $fatal(1, "watchdog expired before the test sequence finished");
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h got %h", name, exp, act);
      $display("Test failures found");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // ====================
  // reference lookup
  // ====================
  // redirect first, then lowest taken lane whose tag is its slot address,
  // else the next block
  function automatic void expect_lookup(input logic bm, input btb_pkg::pc_t mpc,
                                        input btb_pkg::pc_t fpc, output btb_pkg::pc_t exp_pc,
                                        output logic exp_takb, output logic exp_hit);
    btb_pkg::btb_row_t row;
    int                idx;
    row = '0;
    idx = int'(fpc[`BTB_INDEX_LSB +: `BTB_INDEX_BITS]);
    if (model_row.exists(idx)) row = model_row[idx];
    exp_hit  = 1'b0;
    exp_takb = 1'b0;
    exp_pc   = fpc + 32'(`BTB_BLOCK_BYTES);  // sequential fall through
    for (int k = 0; k < `BTB_LANES; k++) begin
      if (!exp_hit && row[k].takb && row[k].pc == fpc + 32'(k * `BTB_INSN_BYTES)) begin
        exp_hit  = 1'b1;
        exp_takb = 1'b1;
        exp_pc   = row[k].tgt;
      end
    end
    if (bm) begin
      exp_pc   = mpc;  // backend redirect beats any hit
      exp_takb = 1'b1;
      exp_hit  = 1'b0;
    end
  endfunction

  // ====================
  // one clock of stimulus
  // ====================
  task automatic drive_cycle(input logic r, input logic fv, input btb_pkg::pc_t fpc,
                             input logic bm, input btb_pkg::pc_t mpc,
                             input btb_pkg::pc_t cbase, input logic [3:0] ctakb,
                             input logic [3:0] cbad);
    logic          exp_valid;
    btb_pkg::pc_t  exp_pc;
    logic          exp_takb;
    logic          exp_hit;
    @(posedge clk);
    // request on the inputs is sampled at this edge while the table still holds old rows
    exp_valid = !rst && (fetch_valid || branch_miss);
    expect_lookup(branch_miss, miss_pc, fetch_pc, exp_pc, exp_takb, exp_hit);
    if (exp_valid && exp_hit) hit_count++;
    if (pend_we) model_row[pend_idx] = pend_row;  // row write from the previous commit
    pend_we  = 1'b0;
    pend_idx = int'(commit_pc[0][`BTB_INDEX_LSB +: `BTB_INDEX_BITS]);
    for (int k = 0; k < `BTB_LANES; k++) begin
      pend_row[k].takb = commit_takb[k];
      pend_row[k].pc   = commit_pc[k];
      pend_row[k].tgt  = commit_tgt[k];
      pend_we          = pend_we | (commit_takb[k] & !rst);
    end
    rst         <= r;
    fetch_valid <= fv;
    fetch_pc    <= fpc;
    branch_miss <= bm;
    miss_pc     <= mpc;
    for (int k = 0; k < `BTB_LANES; k++) begin
      // a bad lane gets a tag that is off its slot address
      commit_pc[k]   <= cbase + 32'(k * `BTB_INSN_BYTES) + (cbad[k] ? 32'h40 : 32'h0);
      commit_tgt[k]  <= rand32();
      commit_takb[k] <= ctakb[k];
    end
    @(negedge clk);  // outputs settled for the request sampled above
    check_value("pred_valid", 32'(exp_valid), 32'(pred_valid));
    if (exp_valid) begin
      check_value("next_pc", exp_pc, next_pc);
      check_value("takb", 32'(exp_takb), 32'(takb));
    end
  endtask

  // ====================
  // test sequence
  // ====================
  initial begin
    logic [31:0]   r;
    logic [31:0]   r2;
    logic [9:0]    idx10;
    btb_pkg::pc_t  fpc;
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_pc    = '0;
    branch_miss = 1'b0;
    miss_pc     = '0;
    for (int k = 0; k < `BTB_LANES; k++) begin
      commit_pc[k]   = '0;
      commit_tgt[k]  = '0;
      commit_takb[k] = 1'b0;
    end
    pend_we   = 1'b0;
    pend_idx  = 0;
    pend_row  = '0;
    hit_count = 0;
    // index field is pc[21:12] and each base lands on its own row
    for (int i = 0; i < 16; i++) begin
      r       = rand32();
      idx10   = 10'(i * 37 + 5);
      pool[i] = {r[31:22], idx10, r[11:0]};
    end

    for (int i = 0; i < RESET_CYCLES; i++) begin
      drive_cycle(i < RESET_CYCLES - 1, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b0, 4'b0);
    end

    drive_cycle(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b0, 4'b0);       // idle
    drive_cycle(1'b0, 1'b1, pool[0], 1'b0, 32'h0, pool[0], 4'b0, 4'b0);     // untouched row
    drive_cycle(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b0100, 4'b0);    // lane 2 taken
    drive_cycle(1'b0, 1'b1, pool[0], 1'b0, 32'h0, pool[0], 4'b0, 4'b0);     // one edge too early
    drive_cycle(1'b0, 1'b1, pool[0], 1'b0, 32'h0, pool[0], 4'b0, 4'b0);     // sees lane 2
    drive_cycle(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b0110, 4'b0);    // lanes 1 and 2
    drive_cycle(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b0, 4'b0);
    drive_cycle(1'b0, 1'b1, pool[0], 1'b0, 32'h0, pool[0], 4'b0, 4'b0);     // lane 1 wins
    drive_cycle(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b0111, 4'b0011); // low tags wrong
    drive_cycle(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b0, 4'b0);
    drive_cycle(1'b0, 1'b1, pool[0], 1'b0, 32'h0, pool[0], 4'b0, 4'b0);     // lane 2 wins
    drive_cycle(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b1000, 4'b0);    // full row replace
    drive_cycle(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b0, 4'b0);
    drive_cycle(1'b0, 1'b1, pool[0], 1'b0, 32'h0, pool[0], 4'b0, 4'b0);     // only lane 3 left
    drive_cycle(1'b0, 1'b1, pool[0], 1'b1, 32'h0000_8000, pool[0], 4'b0, 4'b0);
    drive_cycle(1'b0, 1'b0, 32'h0, 1'b1, 32'h0001_2344, pool[0], 4'b0, 4'b0);
    drive_cycle(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b0, 4'b0);

    // hits are counted over the random mix only
    hit_count = 0;

    // random mix with a request most cycles and a commit about one in four
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r   = rand32();
      r2  = rand32();
      fpc = (r[2:0] == 3'd0) ? rand32() : pool[r[6:3]];
      drive_cycle(1'b0, r[17:16] != 2'd0, fpc, r[21:18] == 4'd0, rand32(), pool[r[10:7]],
                  (r[12:11] == 2'd0) ? r2[3:0] : 4'b0,
                  (r[15:13] == 3'd0) ? r2[7:4] : 4'b0);
    end

    // flush the last request
    drive_cycle(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b0, 4'b0);
    drive_cycle(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, pool[0], 4'b0, 4'b0);

    if (hit_count == 0) begin
      $display("Test failures found");
      $fatal(1, "no random lookup ever hit a taken lane so the table was not exercised");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: logic/btb_commit_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "btb_settings.svh"

// gathers the committed lanes of one fetch block into a single row write
module btb_commit_stage (
  input  logic          clk,
  input  logic          rst,
  input  btb_pkg::pc_t  commit_pc   [`BTB_LANES],  // slot address per lane
  input  btb_pkg::pc_t  commit_tgt  [`BTB_LANES],  // resolved target per lane
  input  logic          commit_takb [`BTB_LANES],  // lane was a taken branch
  btb_ram_if.writer     wr
);

  // ====================
  // next row
  // ====================
  btb_pkg::btb_row_t    row_d;    // lanes packed into a row
  logic                 any_takb; // at least one lane taken
  btb_pkg::btb_index_t  index_d;  // row chosen by lane 0

  always_comb begin
    any_takb = 1'b0;
    for (int k = 0; k < `BTB_LANES; k++) begin
      row_d[k].takb = commit_takb[k];
      row_d[k].pc   = commit_pc[k];   // tag is the full slot address
      row_d[k].tgt  = commit_tgt[k];
      any_takb      = any_takb | commit_takb[k];
    end
  end

  // the block base sits in lane 0, so its bits pick the row
  assign index_d = commit_pc[0][`BTB_INDEX_LSB +: `BTB_INDEX_BITS];

  // ====================
  // write register
  // ====================
  // strobe goes high the cycle after the commit is sampled, the store
  // writes on the edge after that
  always_ff @(posedge clk) begin
    if (rst) begin
      wr.we    <= 1'b0;
      wr.waddr <= '0;
      wr.wrow  <= '0;
    end else begin
      wr.we    <= any_takb;  // not-taken blocks leave the table alone
      wr.waddr <= index_d;
      wr.wrow  <= row_d;     // not-taken lanes go in too, with takb clear
    end
  end

endmodule

`default_nettype wire

// File: logic/btb_pkg.sv
`default_nettype none

`include "btb_settings.svh"

package btb_pkg;

  // ====================
  // basic words
  // ====================
  typedef logic [`BTB_PC_BITS-1:0] pc_t;         // one fetch address
  typedef logic [`BTB_INDEX_BITS-1:0] btb_index_t; // row select

  // one lane of a row, 65 bits
  typedef struct packed {
    logic takb;  // branch in this slot was taken at commit
    pc_t  pc;    // full slot address used as tag
    pc_t  tgt;   // branch target
  } btb_entry_t;

  // ====================
  // row of all lanes, lane 0 in the low bits
  // ====================
  typedef btb_entry_t [`BTB_LANES-1:0] btb_row_t;

endpackage

`default_nettype wire

// File: logic/btb_predict.sv
`timescale 1ns/100ps
`default_nettype none

`include "btb_settings.svh"

// lookup side, one request per cycle, result one cycle later
module btb_predict (
  input  logic          clk,
  input  logic          rst,
  input  logic          fetch_valid,  // fetch_pc holds a block to look up
  input  btb_pkg::pc_t  fetch_pc,     // block base
  input  logic          branch_miss,  // backend redirect
  input  btb_pkg::pc_t  miss_pc,      // redirect address
  btb_ram_if.reader     rd,
  output logic          pred_valid,
  output btb_pkg::pc_t  next_pc,
  output logic          takb
);

  // ====================
  // request stage
  // ====================
  logic          req_valid;    // a result is due this cycle
  logic          req_miss;     // redirect wins over everything
  btb_pkg::pc_t  req_pc;       // block base of the request
  btb_pkg::pc_t  req_miss_pc;  // redirect target

  // read issued straight off the incoming address, the store registers it
  assign rd.raddr = fetch_pc[`BTB_INDEX_LSB +: `BTB_INDEX_BITS];

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
      req_miss  <= 1'b0;
    end else begin
      req_valid <= fetch_valid | branch_miss;  // a miss alone still answers
      req_miss  <= branch_miss;
    end
  end

  // address words, qualified by the flags above
  always_ff @(posedge clk) begin
    req_pc      <= fetch_pc;
    req_miss_pc <= miss_pc;
  end

  // ====================
  // tag compare
  // ====================
  btb_pkg::pc_t            slot_pc [`BTB_LANES];  // address of each slot
  logic [`BTB_LANES-1:0]   lane_hit;              // taken entry with matching tag

  for (genvar k = 0; k < `BTB_LANES; k++) begin : g_lane
    // slot k sits k instructions past the block base
    assign slot_pc[k]  = req_pc + btb_pkg::pc_t'(`BTB_INSN_BYTES * k);
    assign lane_hit[k] = rd.rrow[k].takb && (rd.rrow[k].pc == slot_pc[k]);
  end

  // ====================
  // first taken lane
  // ====================
  logic          any_hit;  // some lane predicts taken
  btb_pkg::pc_t  hit_tgt;  // target of the lowest hitting lane

  always_comb begin
    any_hit = |lane_hit;
    hit_tgt = '0;
    // walk down so the lowest lane is the last one written
    for (int k = `BTB_LANES - 1; k >= 0; k--) begin
      if (lane_hit[k]) begin
        hit_tgt = rd.rrow[k].tgt;
      end
    end
  end

  // ====================
  // next fetch address
  // ====================
  always_comb begin
    if (req_miss) begin
      next_pc = req_miss_pc;  // redirect from the backend
      takb    = 1'b1;
    end else if (any_hit) begin
      next_pc = hit_tgt;      // predicted taken branch in this block
      takb    = 1'b1;
    end else begin
      // fall through to the next block
      next_pc = req_pc + btb_pkg::pc_t'(`BTB_BLOCK_BYTES);
      takb    = 1'b0;
    end
  end

  assign pred_valid = req_valid;  // no holding, consumer takes it now

endmodule

`default_nettype wire

// File: logic/btb_ram_if.sv
`timescale 1ns/100ps
`default_nettype none

// write and read sides of the row store
interface btb_ram_if;

  logic                 we;     // row write strobe
  btb_pkg::btb_index_t  waddr;  // row being written
  btb_pkg::btb_row_t    wrow;   // full row, all lanes
  btb_pkg::btb_index_t  raddr;  // lookup row
  btb_pkg::btb_row_t    rrow;   // row at raddr, one edge later

  // commit side
  modport writer (output we, output waddr, output wrow);

  // lookup side
  modport reader (output raddr, input rrow);

  // the memory itself
  modport store (input we, input waddr, input wrow, input raddr, output rrow);

endinterface

`default_nettype wire

// File: logic/btb_settings.svh
`ifndef BTB_SETTINGS_SVH
`define BTB_SETTINGS_SVH

// ====================
// address and table geometry
// ====================
`define BTB_PC_BITS     32  // fetch address width
`define BTB_INDEX_BITS  10  // 1024 rows
`define BTB_INDEX_LSB   12  // lowest pc bit feeding the row index

// ====================
// fetch block layout
// ====================
`define BTB_LANES       4   // instruction slots per fetch block
`define BTB_INSN_BYTES  5   // bytes per slot
`define BTB_BLOCK_BYTES 20  // sequential step, lanes * slot size

`endif

// File: logic/btb_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "btb_settings.svh"

// simple dual port row memory, one write and one registered read
module btb_store (
  input  logic       clk,
  btb_ram_if.store   ram
);

  // ====================
  // storage
  // ====================
  localparam int unsigned ROWS = 1 << `BTB_INDEX_BITS;  // rows in the table

  // starts out all zero, so every takb bit is clear at power up
  btb_pkg::btb_row_t mem [ROWS] = '{default: '0};

  // ====================
  // write port
  // ====================
  always_ff @(posedge clk) begin
    if (ram.we) begin
      mem[ram.waddr] <= ram.wrow;  // whole row, every lane replaced
    end
  end

  // ====================
  // read port
  // ====================
  // nonblocking read of the array, so a write to the same row on the
  // same edge is not seen until the next read
  always_ff @(posedge clk) begin
    ram.rrow <= mem[ram.raddr];  // one edge of latency
  end

endmodule

`default_nettype wire

// File: logic/btb_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "btb_settings.svh"

// four-lane branch target buffer for a 20-byte fetch block
module btb_top (
  input  logic          clk,
  input  logic          rst,

  // ====================
  // fetch side
  // ====================
  input  logic          fetch_valid,
  input  btb_pkg::pc_t  fetch_pc,     // block base address
  input  logic          branch_miss,  // mispredict redirect
  input  btb_pkg::pc_t  miss_pc,

  // ====================
  // commit side
  // ====================
  input  btb_pkg::pc_t  commit_pc   [`BTB_LANES],
  input  btb_pkg::pc_t  commit_tgt  [`BTB_LANES],
  input  logic          commit_takb [`BTB_LANES],

  // ====================
  // prediction
  // ====================
  output logic          pred_valid,   // one cycle after the request
  output btb_pkg::pc_t  next_pc,
  output logic          takb
);

  // row store ports shared by the three blocks
  btb_ram_if ram_if ();

  // commit lanes to row write
  btb_commit_stage i_btb_commit_stage (
    .clk         (clk),
    .rst         (rst),
    .commit_pc   (commit_pc),
    .commit_tgt  (commit_tgt),
    .commit_takb (commit_takb),
    .wr          (ram_if.writer)
  );

  // the table itself, no reset on contents
  btb_store i_btb_store (
    .clk (clk),
    .ram (ram_if.store)
  );

  // lookup and next pc selection
  btb_predict i_btb_predict (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .branch_miss (branch_miss),
    .miss_pc     (miss_pc),
    .rd          (ram_if.reader),
    .pred_valid  (pred_valid),
    .next_pc     (next_pc),
    .takb        (takb)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the btb testbench with verilator and run it
# exit status is nonzero when the build fails or the run stops on $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module btb_tb -f src.f -o btb_sim \
  && ./obj_dir/btb_sim \
  || { echo "btb simulation did not complete cleanly"; exit 1; }

echo "btb simulation exited with status 0"

// File: src.f
+incdir+logic
logic/btb_pkg.sv
logic/btb_ram_if.sv
logic/btb_store.sv
logic/btb_commit_stage.sv
logic/btb_predict.sv
logic/btb_top.sv
dv/btb_assert.sv
dv/btb_tb.sv
